/* io_uart.f */
design/io_uart_pkg.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_regs.sv
design/ior_status_reg.sv
design/io_uart.sv
dv/io_uart_props.sv
dv/io_uart_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the console UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f io_uart.f --top-module io_uart_tb -o io_uart_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/io_uart_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1

/* dv/io_uart_tb.sv */
// ------------------------------------------------------------
// Console UART testbench
// Bus tasks, serial line model, txd monitor and result checks
// ------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module io_uart_tb
   import io_uart_pkg::*;
();

   logic        clk;
   logic        reset;
   logic        uart_sel;
   logic        rd;
   logic        wr;
   logic [1:0]  addr;
   logic [7:0]  wdata;
   logic        ior_rd;
   logic        rxd;
   logic        i1p;
   logic        eauto_n;
   logic        lock_n;
   logic        console_n;
   logic [4:0]  baud_rate_switch;
   logic [15:0] rdata;
   logic        txd;
   logic        o1p;
   logic        o2p;
   logic        da_n;
   logic        tbmt_n;

   logic [31:0] lfsr_q;       // Random source state
   logic [7:0]  tx_exp[$];    // Characters still due on txd
   int          tx_got;       // Frames decoded by the monitor
   int          errors;
   int          timeouts;
   bit          loop_mode;    // Line outputs must stay at mark
   int          div;          // Clocks per bit at the current switches

   io_uart dut (.*);

   always #4 clk = ~clk;   // 8 ns period

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[6:0], lfsr_q[0]};
      end
   endtask

   function automatic int bit_clocks(input logic [4:0] sw);
      return (int'(sw) + 1) * 8;   // Eight clocks per switch step
   endfunction

   // Reference IOR word with flags and straps in their field slots
   function automatic logic [15:0] expect_ior(input logic tb_n, input logic d_n,
         input logic ea_n, input logic lk_n, input logic co_n, input logic [4:0] sw);
      ior_word_u w;
      w.raw         = '0;
      w.f.tbmt_n    = tb_n;
      w.f.da_n      = d_n;
      w.f.eauto_n   = ea_n;
      w.f.lock_n    = lk_n;
      w.f.console_n = co_n;
      w.f.baud      = sw;
      return w.raw;
   endfunction

   // Reference status byte
   function automatic logic [7:0] expect_status(input logic txrdy, input logic rxrdy,
         input logic txemt, input logic ovr);
      return {3'b000, ovr, 1'b0, txemt, rxrdy, txrdy};
   endfunction

   task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
      @(negedge clk);
      uart_sel = 1'b1;
      wr       = 1'b1;
      addr     = a;
      wdata    = d;
      @(negedge clk);   // Takes effect on the edge in between
      uart_sel = 1'b0;
      wr       = 1'b0;
   endtask

   // UART read or IOR read when ior is set
   task automatic bus_read(input logic [1:0] a, input bit ior, output logic [15:0] d);
      @(negedge clk);
      uart_sel = !ior;
      rd       = !ior;
      ior_rd   = ior;
      addr     = a;
      @(negedge clk);
      uart_sel = 1'b0;
      rd       = 1'b0;
      ior_rd   = 1'b0;
      d = rdata;   // Registered and valid one cycle after the strobe
   endtask

   // Polls da_n or tbmt_n for a level
   task automatic wait_flag(input bit use_da, input logic val, input int limit);
      int n;
      n = 0;
      while ((use_da ? da_n : tbmt_n) !== val && n < limit) begin
         @(negedge clk);
         n++;
      end
      if ((use_da ? da_n : tbmt_n) !== val) begin
         timeouts++;
         $display("Timeout at %0t waiting for %s to reach %b", $time,
                  use_da ? "da_n" : "tbmt_n", val);
      end
   endtask

   task automatic wait_frames(input int count, input int limit);
      int n;
      n = 0;
      while (tx_got < count && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (tx_got < count) begin
         timeouts++;
         $display("Timeout: only %0d of %0d frames seen on txd", tx_got, count);
      end
   endtask

   // 8N1 frame on rxd or on the current loop with rxd held at space
   task automatic send_frame(input logic [7:0] d, input bit on_loop);
      logic [9:0] frame;
      frame = {1'b1, d, 1'b0};
      @(negedge clk);
      if (on_loop) begin
         rxd = 1'b0;
         i1p = 1'b1;
      end
      for (int i = 0; i < 10; i++) begin
         if (on_loop) i1p = frame[i];
         else         rxd = frame[i];
         repeat (div) @(negedge clk);
      end
      repeat (div) @(negedge clk);   // Idle gap so the flags settle
      rxd = 1'b1;
      i1p = 1'b0;
   endtask

   // txd monitor sampling each bit at its centre
   initial begin
      logic [7:0] b;
      forever begin
         @(negedge clk);
         // Current loop pair copies txd
         if (!loop_mode) compare("o1p/o2p", {14'h0, o1p, o2p}, {14'h0, txd, txd});
         if (loop_mode) begin
            compare("txd/o1p/o2p", {13'h0, txd, o1p, o2p}, 16'h0007);
         end else if (txd === 1'b0) begin
            repeat (div / 2) @(negedge clk);
            compare("txd start", {15'h0, txd}, 16'h0000);
            for (int i = 0; i < 8; i++) begin
               repeat (div) @(negedge clk);
               b[i] = txd;   // LSB first
            end
            repeat (div) @(negedge clk);
            compare("txd stop", {15'h0, txd}, 16'h0001);
            if (tx_exp.size() == 0) begin
               errors++;
               $display("Unexpected frame on txd at %0t", $time);
            end else begin
               compare("txd data", {8'h00, b}, {8'h00, tx_exp.pop_front()});
            end
            tx_got++;
         end
      end
   end

   initial begin
      logic [15:0] d;
      logic [7:0]  r;
      logic [7:0]  c;
      logic [7:0]  c2;
      logic [4:0]  sw;
      clk              = 1'b0;
      reset            = 1'b1;
      uart_sel         = 1'b0;
      rd               = 1'b0;
      wr               = 1'b0;
      addr             = 2'd0;
      wdata            = 8'h00;
      ior_rd           = 1'b0;
      rxd              = 1'b1;   // Mark
      i1p              = 1'b0;
      eauto_n          = 1'b1;
      lock_n           = 1'b1;
      console_n        = 1'b1;
      baud_rate_switch = 5'd0;
      lfsr_q           = 32'h702082f3;
      errors           = 0;
      timeouts         = 0;
      tx_got           = 0;
      loop_mode        = 1'b0;
      div              = 8;
      repeat (2) @(negedge clk);
      reset = 1'b0;

      // Reset state
      @(negedge clk);
      compare("tbmt_n", {15'h0, tbmt_n}, 16'h0000);
      compare("da_n", {15'h0, da_n}, 16'h0001);
      compare("txd", {15'h0, txd}, 16'h0001);
      compare("rdata", rdata, 16'h0000);
      bus_read(addr_status, 1'b0, d);
      compare("status", d, {8'h00, expect_status(1'b1, 1'b0, 1'b1, 1'b0)});

      // IOR word with random straps and switches
      for (int k = 0; k < 6; k++) begin
         take_bits(5, r);
         sw = r[4:0];
         take_bits(3, r);
         baud_rate_switch = sw;
         eauto_n          = r[2];
         lock_n           = r[1];
         console_n        = r[0];
         repeat (2) @(negedge clk);   // Latched every clock
         bus_read(2'd0, 1'b1, d);
         compare("ior word", d, expect_ior(1'b0, 1'b1, r[2], r[1], r[0], sw));
      end

      // Operating rate takes effect at the next baud wrap
      take_bits(5, r);
      baud_rate_switch = r[4:0];
      div = bit_clocks(r[4:0]);
      repeat (520) @(negedge clk);

      // Back to back transmit through the holding register
      bus_write(addr_cmd, 8'h01);
      for (int k = 0; k < 16; k++) begin
         take_bits(8, c);
         wait_flag(1'b0, 1'b0, 12 * div + 16);
         tx_exp.push_back(c);
         bus_write(addr_data, c);
      end
      wait_frames(16, 20 * 10 * div);

      // Receive on rxd and then on the current loop
      bus_write(addr_cmd, 8'h05);
      for (int k = 0; k < 2; k++) begin
         take_bits(8, c);
         send_frame(c, k == 1);
         wait_flag(1'b1, 1'b0, 4 * div);
         bus_read(addr_status, 1'b0, d);
         compare("status", d, {8'h00, expect_status(1'b1, 1'b1, 1'b1, 1'b0)});
         bus_read(addr_data, 1'b0, d);
         compare("rx data", d, {8'h00, c});
         compare("da_n", {15'h0, da_n}, 16'h0001);
      end

      // Overrun where the second character wins
      take_bits(8, c);
      take_bits(8, c2);
      send_frame(c, 1'b0);
      send_frame(c2, 1'b0);
      wait_flag(1'b1, 1'b0, 4 * div);
      bus_read(addr_status, 1'b0, d);
      compare("status", d, {8'h00, expect_status(1'b1, 1'b1, 1'b1, 1'b1)});
      bus_read(addr_data, 1'b0, d);
      compare("rx data", d, {8'h00, c2});
      bus_read(addr_status, 1'b0, d);
      compare("status", d, {8'h00, expect_status(1'b1, 1'b0, 1'b1, 1'b0)});

      // Local loopback with line outputs held at mark
      bus_write(addr_cmd, 8'h85);
      loop_mode = 1'b1;
      for (int k = 0; k < 4; k++) begin
         take_bits(8, c);
         wait_flag(1'b0, 1'b0, 12 * div + 16);
         bus_write(addr_data, c);
         wait_flag(1'b1, 1'b0, 14 * div);
         bus_read(addr_data, 1'b0, d);
         compare("loop data", d, {8'h00, c});
      end
      loop_mode = 1'b0;

      $display("Summary: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dv/io_uart_props.sv */
// ------------------------------------------------------------
// Bound checks on the TX handshake and the UART read bus
// ------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module io_uart_props (
   input wire logic        clk,
   input wire logic        reset,
   input wire logic        tx_idle,
   input wire logic        txd,
   input wire logic        tx_load,
   input wire logic        tx_empty,
   input wire logic        strobe,     // Read strobe of the bound block
   input wire logic [15:0] rdata
);

   // Line at mark whenever the shifter is idle
   idle_mark: assert property (@(posedge clk) disable iff (reset) tx_idle |-> txd)
      else $error("txd low while the shifter is idle");

   // Load goes into an empty holding register and fills it
   load_empty: assert property (@(posedge clk) disable iff (reset)
         tx_load |-> tx_empty ##1 !tx_empty)
      else $error("tx_load into a full holding register or holding register not filled");

   // OR bus needs zero after an idle cycle
   rdata_zero: assert property (@(posedge clk) disable iff (reset) !strobe |=> rdata == '0)
      else $error("rdata not zero after a cycle without a read strobe");

endmodule

// Transmit shifter
bind uart_tx io_uart_props u_tx_props (
   .clk(clk), .reset(reset), .tx_idle(tx_idle), .txd(txd), .tx_load(tx_load),
   .tx_empty(tx_empty), .strobe(1'b1), .rdata(16'h0000));

// UART register file
bind uart_regs io_uart_props u_regs_props (
   .clk(clk), .reset(reset), .tx_idle(tx_idle), .txd(1'b1), .tx_load(tx_load),
   .tx_empty(tx_empty), .strobe(rd_s), .rdata(rdata));

`default_nettype wire

/* design/io_uart.sv */
// ------------------------------------------------------------
// Console serial port top level
// UART, IOR status register, loop lines and shared read bus
// ------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module io_uart
   import io_uart_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              uart_sel,
   input  wire logic              rd,
   input  wire logic              wr,
   input  wire logic [1:0]        addr,
   input  wire logic [data_w-1:0] wdata,
   input  wire logic              ior_rd,
   input  wire logic              rxd,
   input  wire logic              i1p,        // Current loop in
   input  wire logic              eauto_n,
   input  wire logic              lock_n,
   input  wire logic              console_n,
   input  wire logic [baud_w-1:0] baud_rate_switch,
   output logic [bus_w-1:0]       rdata,
   output logic                   txd,
   output logic                   o1p,        // Current loop out
   output logic                   o2p,
   output logic                   da_n,
   output logic                   tbmt_n
);

   logic              tick;
   logic              tx_load;
   logic [data_w-1:0] tx_byte;
   logic              rx_take;
   logic              txen;
   logic              rxen;
   logic              loop;
   logic              tx_line;      // Shifter output
   logic              tx_empty;
   logic              tx_idle;
   logic              rx_line;
   logic              rx_valid;
   logic [data_w-1:0] rx_byte;
   logic              overrun;
   logic              line_out;
   logic [bus_w-1:0]  uart_rdata;
   logic [bus_w-1:0]  ior_rdata;

   // RS232 and current loop share the receiver; loopback takes the shifter instead
   assign rx_line  = loop ? tx_line : (rxd | i1p);
   assign line_out = loop ? 1'b1 : tx_line;   // Mark outside during loopback
   assign txd      = line_out;
   assign o1p      = line_out;
   assign o2p      = line_out;

   assign tbmt_n = ~tx_empty;   // Ready flags are active low
   assign da_n   = ~rx_valid;
   assign rdata  = uart_rdata | ior_rdata;   // Only one source reads at a time

   uart_baud_gen u_baud (
      .clk(clk), .reset(reset), .baud_rate_switch(baud_rate_switch), .tick(tick));

   uart_tx u_tx (
      .clk(clk), .reset(reset), .tick(tick), .txen(txen), .tx_load(tx_load),
      .tx_byte(tx_byte), .txd(tx_line), .tx_empty(tx_empty), .tx_idle(tx_idle));

   uart_rx u_rx (
      .clk(clk), .reset(reset), .rxen(rxen), .rx_line(rx_line), .rx_take(rx_take),
      .baud_rate_switch(baud_rate_switch), .rx_valid(rx_valid), .rx_byte(rx_byte),
      .overrun(overrun));

   uart_regs u_regs (
      .clk(clk), .reset(reset), .uart_sel(uart_sel), .rd(rd), .wr(wr), .addr(addr),
      .wdata(wdata), .tx_empty(tx_empty), .tx_idle(tx_idle), .rx_valid(rx_valid),
      .rx_byte(rx_byte), .overrun(overrun), .tx_load(tx_load), .tx_byte(tx_byte),
      .rx_take(rx_take), .txen(txen), .rxen(rxen), .loop(loop), .rdata(uart_rdata));

   ior_status_reg u_ior (
      .clk(clk), .reset(reset), .ior_rd(ior_rd), .tbmt_n(tbmt_n), .da_n(da_n),
      .eauto_n(eauto_n), .lock_n(lock_n), .console_n(console_n),
      .baud_rate_switch(baud_rate_switch), .rdata(ior_rdata));

endmodule

`default_nettype wire

/* design/ior_status_reg.sv */
// ------------------------------------------------------------
// IOR status register
// Latched flags, straps and baud switches as one bus word
// ------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module ior_status_reg
   import io_uart_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              ior_rd,
   input  wire logic              tbmt_n,
   input  wire logic              da_n,
   input  wire logic              eauto_n,
   input  wire logic              lock_n,
   input  wire logic              console_n,
   input  wire logic [baud_w-1:0] baud_rate_switch,
   output logic [bus_w-1:0]       rdata
);

   ior_word_u        word_d;
   ior_word_u        word_q;    // Sampled every clock
   logic [bus_w-1:0] rdata_q;

   always_comb begin
      word_d             = '0;   // Middle field stays zero
      word_d.f.tbmt_n    = tbmt_n;
      word_d.f.da_n      = da_n;
      word_d.f.eauto_n   = eauto_n;
      word_d.f.lock_n    = lock_n;
      word_d.f.console_n = console_n;
      word_d.f.baud      = baud_rate_switch;
   end

   always_ff @(posedge clk) word_q <= word_d;

   // Output enable, one cycle after the strobe
   always_ff @(posedge clk) begin
      if (reset) rdata_q <= '0;
      else       rdata_q <= ior_rd ? word_q.raw : '0;
   end

   assign rdata = rdata_q;

endmodule

`default_nettype wire

/* design/uart_regs.sv */
// ------------------------------------------------------------
// UART register file
// Bus decode, command register, status byte and read data
// ------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module uart_regs
   import io_uart_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              uart_sel,
   input  wire logic              rd,
   input  wire logic              wr,
   input  wire logic [1:0]        addr,
   input  wire logic [data_w-1:0] wdata,
   input  wire logic              tx_empty,
   input  wire logic              tx_idle,
   input  wire logic              rx_valid,
   input  wire logic [data_w-1:0] rx_byte,
   input  wire logic              overrun,
   output logic                   tx_load,
   output logic [data_w-1:0]      tx_byte,
   output logic                   rx_take,
   output logic                   txen,
   output logic                   rxen,
   output logic                   loop,
   output logic [bus_w-1:0]       rdata
);

   logic              rd_s;
   logic              wr_s;
   logic [data_w-1:0] cmd_q;      // Command register
   logic              ovr_q;      // Sticky overrun
   logic [data_w-1:0] status;
   logic [data_w-1:0] rd_byte;    // Selected register
   logic [bus_w-1:0]  rdata_q;

   assign rd_s = uart_sel & rd;
   assign wr_s = uart_sel & wr;

   // Data write dropped while the holding register is full
   assign tx_load = wr_s & (addr == addr_data) & tx_empty;
   assign tx_byte = wdata;
   assign rx_take = rd_s & (addr == addr_data);   // Clears rx_valid next edge

   assign txen = cmd_q[cmd_txen];
   assign rxen = cmd_q[cmd_rxen];
   assign loop = cmd_q[cmd_loop];

   always_comb begin
      status           = '0;
      status[st_txrdy] = tx_empty;
      status[st_rxrdy] = rx_valid;
      status[st_txemt] = tx_idle;
      status[st_ovr]   = ovr_q;
   end

   always_comb begin
      case (addr)
         addr_data:   rd_byte = rx_byte;
         addr_status: rd_byte = status;
         addr_cmd:    rd_byte = cmd_q;
         default:     rd_byte = '0;   // Unused slot
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_q   <= '0;   // TX and RX disabled
         ovr_q   <= 1'b0;
         rdata_q <= '0;
      end else begin
         if (wr_s && addr == addr_cmd) cmd_q <= wdata;
         if (overrun) begin
            ovr_q <= 1'b1;   // New event beats a clearing read
         end else if (rd_s && addr == addr_status) begin
            ovr_q <= 1'b0;
         end
         rdata_q <= rd_s ? {{(bus_w - data_w){1'b0}}, rd_byte} : '0;   // Zero for OR bus
      end
   end

   assign rdata = rdata_q;

endmodule

`default_nettype wire

/* design/uart_rx.sv */
// ------------------------------------------------------------
// UART receiver
// Start-bit hunt, mid-bit sampling, holding register, overrun
// ------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module uart_rx
   import io_uart_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              rxen,
   input  wire logic              rx_line,
   input  wire logic              rx_take,
   input  wire logic [baud_w-1:0] baud_rate_switch,
   output logic                   rx_valid,
   output logic [data_w-1:0]      rx_byte,
   output logic                   overrun
);

   logic [2:0]        sync_q;      // Two sync stages plus edge delay
   logic              line_s;      // Synchronized line
   logic              fall;        // Mark to space edge
   logic [div_w-1:0]  div;
   logic [div_w-1:0]  half;
   logic [div_w-1:0]  cnt_q;       // Own phase counter
   logic [3:0]        bit_idx_q;   // 0 start, 1..8 data, 9 stop
   logic              busy_q;
   logic              sample;      // Mid-bit point
   logic              is_start;
   logic              is_stop;
   logic              frame_ok;    // Good stop bit seen
   logic [data_w-1:0] shift_q;
   logic [data_w-1:0] rx_byte_q;
   logic              rx_valid_q;
   logic              ovr_q;

   assign line_s   = sync_q[1];
   assign fall     = sync_q[2] & ~sync_q[1];
   assign div      = baud_divisor_f(baud_rate_switch);
   assign half     = div >> 1;
   assign sample   = busy_q & (cnt_q == '0);
   assign is_start = (bit_idx_q == 4'd0);
   assign is_stop  = (bit_idx_q == 4'(frame_bits - 1));
   assign frame_ok = sample & is_stop & line_s;   // Low stop bit drops frame

   always_ff @(posedge clk) begin
      if (reset) begin
         sync_q     <= '1;     // Line idles at mark
         busy_q     <= 1'b0;
         bit_idx_q  <= '0;
         cnt_q      <= '0;
         rx_valid_q <= 1'b0;
         ovr_q      <= 1'b0;
      end else begin
         sync_q <= {sync_q[1:0], rx_line};
         ovr_q  <= 1'b0;   // Single-cycle event
         if (!busy_q) begin
            if (rxen && fall) begin
               busy_q    <= 1'b1;
               bit_idx_q <= '0;
               cnt_q     <= half - 1'b1;   // Centre of start bit
            end
         end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
         end else begin
            cnt_q     <= div - 1'b1;   // One full bit to the next centre
            bit_idx_q <= bit_idx_q + 1'b1;
            if (is_start && line_s) begin
               busy_q <= 1'b0;   // Glitch, not a start bit
            end else if (is_stop) begin
               busy_q <= 1'b0;
            end
         end
         if (frame_ok) begin
            rx_valid_q <= 1'b1;
            ovr_q      <= rx_valid_q & ~rx_take;   // Unread char overwritten
         end else if (rx_take) begin
            rx_valid_q <= 1'b0;
         end
      end
   end

   // Data bits, LSB arrives first
   always_ff @(posedge clk) begin
      if (sample && !is_start && !is_stop) shift_q <= {line_s, shift_q[data_w-1:1]};
      if (frame_ok) rx_byte_q <= shift_q;
   end

   assign rx_valid = rx_valid_q;
   assign rx_byte  = rx_byte_q;
   assign overrun  = ovr_q;   // Pulse, regs keep the sticky flag

endmodule

`default_nettype wire

/* design/uart_tx.sv */
// ------------------------------------------------------------
// UART transmitter
// Holding register feeding a 10-bit 8N1 shift frame
// ------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module uart_tx
   import io_uart_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              tick,
   input  wire logic              txen,
   input  wire logic              tx_load,
   input  wire logic [data_w-1:0] tx_byte,
   output logic                   txd,
   output logic                   tx_empty,
   output logic                   tx_idle
);

   logic [data_w-1:0]     hold_q;        // Holding register
   logic                  hold_full_q;
   logic [frame_bits-1:0] shift_q;       // Bit 0 is on the line
   logic [3:0]            bit_cnt_q;     // Bit period within frame
   logic                  active_q;      // Frame loaded in shifter
   logic                  started_q;     // Start bit reached the line
   logic                  xfer;          // Holding -> shifter
   logic                  shift_en;
   logic                  last_bit;

   assign xfer     = hold_full_q & ~active_q & txen;
   assign last_bit = (bit_cnt_q == 4'(frame_bits - 1));
   assign shift_en = active_q & tick & started_q & ~last_bit;

   always_ff @(posedge clk) begin
      if (tx_load) hold_q <= tx_byte;
      if (xfer) begin
         shift_q <= {1'b1, hold_q, 1'b0};       // Stop, data, start
      end else if (shift_en) begin
         shift_q <= {1'b1, shift_q[frame_bits-1:1]};   // LSB first
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         hold_full_q <= 1'b0;
         active_q    <= 1'b0;
         started_q   <= 1'b0;
         bit_cnt_q   <= '0;
      end else begin
         if (tx_load) hold_full_q <= 1'b1;   // Only offered when empty
         if (xfer) begin
            hold_full_q <= 1'b0;   // Free for the next character
            active_q    <= 1'b1;
            started_q   <= 1'b0;   // Wait for a tick boundary
            bit_cnt_q   <= '0;
         end else if (active_q && tick) begin
            if (!started_q) begin
               started_q <= 1'b1;   // Start bit begins
            end else if (last_bit) begin
               active_q  <= 1'b0;   // Stop bit done
               started_q <= 1'b0;
            end else begin
               bit_cnt_q <= bit_cnt_q + 1'b1;
            end
         end
      end
   end

   assign txd      = started_q ? shift_q[0] : 1'b1;   // Mark when idle
   assign tx_empty = ~hold_full_q;
   assign tx_idle  = ~active_q;

endmodule

`default_nettype wire

/* design/uart_baud_gen.sv */
// ------------------------------------------------------------
// Baud generator
// One-clock tick per bit period, divisor from the switches
// ------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module uart_baud_gen
   import io_uart_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic [baud_w-1:0] baud_rate_switch,
   output logic                   tick
);

   logic [div_w-1:0] div;     // Clocks per bit
   logic [div_w-1:0] cnt_q;   // Down-counter

   assign div = baud_divisor_f(baud_rate_switch);

   // Free-running, reloads at zero
   // New switch value is picked up only on the reload
   always_ff @(posedge clk) begin
      if (reset) begin
         cnt_q <= div - 1'b1;
      end else if (cnt_q == '0) begin
         cnt_q <= div - 1'b1;   // Wrap
      end else begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   assign tick = (cnt_q == '0);   // Exactly one cycle per period

endmodule

`default_nettype wire

/* design/io_uart_pkg.sv */
// ------------------------------------------------------------
// Console UART shared definitions
// Widths, baud divisor rule, register map and IOR word layout
// ------------------------------------------------------------
`default_nettype none

package io_uart_pkg;

   // Datapath widths
   localparam int data_w     = 8;            // Character width
   localparam int bus_w      = 16;           // I/O data bus
   localparam int baud_w     = 5;            // Baud switch field
   localparam int div_w      = 12;           // Bit-period counter
   localparam int frame_bits = data_w + 2;   // Start + data + stop

   // UART register addresses, address 3 reads as zero
   localparam logic [1:0] addr_data   = 2'd0;
   localparam logic [1:0] addr_status = 2'd1;
   localparam logic [1:0] addr_cmd    = 2'd2;

   // Command register bits
   localparam int cmd_txen = 0;   // Transmit enable
   localparam int cmd_rxen = 2;   // Receive enable
   localparam int cmd_loop = 7;   // Local loopback

   // Status register bits
   localparam int st_txrdy = 0;   // Holding register empty
   localparam int st_rxrdy = 1;   // Received character held
   localparam int st_txemt = 2;   // Shifter idle
   localparam int st_ovr   = 4;   // Overrun, sticky until status read

   // IOR word, raw bus view or strap/flag fields
   typedef union packed {
      logic [bus_w-1:0] raw;
      struct packed {
         logic              tbmt_n;      // Bit 15
         logic              da_n;
         logic              eauto_n;
         logic              lock_n;
         logic              console_n;   // Bit 11
         logic [5:0]        rsvd;        // Always zero
         logic [baud_w-1:0] baud;        // Switches, bits 4..0
      } f;
   } ior_word_u;

   // Clocks per bit for a switch setting
   // (switch + 1) * 8, range 8 to 256
   function automatic logic [div_w-1:0] baud_divisor_f(input logic [baud_w-1:0] sw);
      logic [div_w-1:0] div;
      div = (div_w'(sw) + 1'b1) << 3;
      return div;
   endfunction

endpackage

`default_nettype wire
